// File: hw/core_pkg.sv
package core_pkg;

    localparam int unsigned xlen = 32;
    localparam logic [xlen-1:0] reset_pc = '0;

    // ====================
    // major opcodes
    // ====================
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_jal    = 7'b1101111;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_pass_b
    } alu_op_e;

    // ====================
    // pipeline packets
    // ====================
    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [31:0]     instr;
    } fetch_pkt_t;

    typedef struct packed {
        logic            valid;
        logic            illegal;
        logic [xlen-1:0] pc;
        logic [4:0]      rd;
        logic            we;
        alu_op_e         alu_op;
        logic [xlen-1:0] op_a;
        // immediate or rs2, already selected
        logic [xlen-1:0] op_b;
        logic [xlen-1:0] rs2_val;
        logic            is_branch;
        logic            branch_ne;
        logic            is_jal;
        logic [xlen-1:0] imm;
    } dec_pkt_t;

    typedef struct packed {
        logic [xlen-1:0] alu_res;
        logic            taken;
        logic [xlen-1:0] target;
    } exec_res_t;

    typedef struct packed {
        logic            valid;
        logic            illegal;
        logic [xlen-1:0] pc;
        logic [4:0]      rd;
        logic            we;
        logic [xlen-1:0] data;
    } retire_t;

endpackage

// File: hw/fetch_unit.sv
module fetch_unit import core_pkg::*; (
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic            redirect_valid_i,
    input  logic [xlen-1:0] redirect_pc_i,
    output logic            wb_cyc_o,
    output logic            wb_stb_o,
    output logic            wb_we_o,
    output logic [xlen-1:0] wb_adr_o,
    input  logic [31:0]     wb_dat_i,
    input  logic            wb_ack_i,
    output fetch_pkt_t      fetch_o
);

    logic            cyc_q;
    logic            discard_q;
    logic [xlen-1:0] pc_q;
    // target held while a stale request drains
    logic [xlen-1:0] pend_pc_q;
    fetch_pkt_t      fetch_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cyc_q     <= 1'b0;
            discard_q <= 1'b0;
            pc_q      <= reset_pc;
            pend_pc_q <= reset_pc;
            fetch_q   <= '0;
        end else begin
            fetch_q.valid <= 1'b0;
            if (!cyc_q) begin
                // first request after reset
                cyc_q <= 1'b1;
            end else if (wb_ack_i) begin
                discard_q <= 1'b0;
                if (redirect_valid_i) begin
                    pc_q <= redirect_pc_i;
                end else if (discard_q) begin
                    pc_q <= pend_pc_q;
                end else begin
                    pc_q          <= pc_q + xlen'(4);
                    fetch_q.valid <= 1'b1;
                    fetch_q.pc    <= pc_q;
                    fetch_q.instr <= wb_dat_i;
                end
            end else if (redirect_valid_i) begin
                // request in flight, let it finish and drop the data
                discard_q <= 1'b1;
                pend_pc_q <= redirect_pc_i;
            end
        end
    end

    assign wb_cyc_o = cyc_q;
    assign wb_stb_o = cyc_q;
    assign wb_we_o  = 1'b0;
    assign wb_adr_o = pc_q;
    assign fetch_o  = fetch_q;

    // strobe and address held through wait states
    assert property (@(posedge clk) disable iff (!rst_n_i)
        wb_stb_o && !wb_ack_i |=> wb_stb_o && $stable(wb_adr_o));

    assert property (@(posedge clk) disable iff (!rst_n_i) wb_cyc_o |-> !wb_we_o);

endmodule

// File: hw/decoder.sv
module decoder import core_pkg::*; (
    input  logic            clk,
    input  logic            rst_n_i,
    input  fetch_pkt_t      fetch_i,
    input  logic            flush_i,
    output logic [4:0]      rs1_addr_o,
    output logic [4:0]      rs2_addr_o,
    input  logic [xlen-1:0] rs1_data_i,
    input  logic [xlen-1:0] rs2_data_i,
    output dec_pkt_t        dec_o
);

    logic [31:0]     instr;
    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] imm_j;
    logic [xlen-1:0] imm_u;
    dec_pkt_t        dec_d;
    dec_pkt_t        dec_q;

    assign instr  = fetch_i.instr;
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign rs1_addr_o = instr[19:15];
    assign rs2_addr_o = instr[24:20];

    // ====================
    // immediates
    // ====================
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};

    always_comb begin
        dec_d         = '0;
        dec_d.valid   = fetch_i.valid && !flush_i;
        dec_d.pc      = fetch_i.pc;
        dec_d.rd      = instr[11:7];
        dec_d.op_a    = rs1_data_i;
        dec_d.op_b    = rs2_data_i;
        dec_d.rs2_val = rs2_data_i;
        dec_d.alu_op  = alu_add;
        dec_d.imm     = imm_i;
        case (opcode)
            opc_op: begin
                dec_d.we = 1'b1;
                case (funct3)
                    3'b000:  dec_d.alu_op = funct7[5] ? alu_sub : alu_add;
                    3'b001:  dec_d.alu_op = alu_sll;
                    3'b010:  dec_d.alu_op = alu_slt;
                    3'b011:  dec_d.alu_op = alu_sltu;
                    3'b100:  dec_d.alu_op = alu_xor;
                    3'b101:  dec_d.alu_op = funct7[5] ? alu_sra : alu_srl;
                    3'b110:  dec_d.alu_op = alu_or;
                    default: dec_d.alu_op = alu_and;
                endcase
                // only sub and sra may set bit 30
                if ((funct7 & 7'b1011111) != 7'b0) begin
                    dec_d.illegal = 1'b1;
                end
                if (funct7[5] && funct3 != 3'b000 && funct3 != 3'b101) begin
                    dec_d.illegal = 1'b1;
                end
            end
            opc_op_imm: begin
                dec_d.we   = 1'b1;
                dec_d.op_b = imm_i;
                case (funct3)
                    3'b000:  dec_d.alu_op = alu_add;
                    3'b001:  dec_d.alu_op = alu_sll;
                    3'b010:  dec_d.alu_op = alu_slt;
                    3'b011:  dec_d.alu_op = alu_sltu;
                    3'b100:  dec_d.alu_op = alu_xor;
                    3'b101:  dec_d.alu_op = funct7[5] ? alu_sra : alu_srl;
                    3'b110:  dec_d.alu_op = alu_or;
                    default: dec_d.alu_op = alu_and;
                endcase
                if (funct3 == 3'b001 && funct7 != 7'b0) begin
                    dec_d.illegal = 1'b1;
                end
                if (funct3 == 3'b101 && (funct7 & 7'b1011111) != 7'b0) begin
                    dec_d.illegal = 1'b1;
                end
            end
            opc_lui: begin
                dec_d.we     = 1'b1;
                dec_d.imm    = imm_u;
                dec_d.op_b   = imm_u;
                dec_d.alu_op = alu_pass_b;
            end
            opc_branch: begin
                dec_d.is_branch = 1'b1;
                dec_d.branch_ne = funct3[0];
                dec_d.imm       = imm_b;
                if (funct3[2:1] != 2'b00) begin
                    dec_d.illegal = 1'b1;
                end
            end
            opc_jal: begin
                dec_d.we     = 1'b1;
                dec_d.is_jal = 1'b1;
                dec_d.imm    = imm_j;
            end
            default: dec_d.illegal = 1'b1;
        endcase
        // illegal words must neither write nor redirect
        if (dec_d.illegal) begin
            dec_d.we        = 1'b0;
            dec_d.is_branch = 1'b0;
            dec_d.is_jal    = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dec_q <= '0;
        end else begin
            dec_q <= dec_d;
        end
    end

    assign dec_o = dec_q;

    assert property (@(posedge clk) disable iff (!rst_n_i) dec_o.illegal |-> !dec_o.we);

endmodule

// File: hw/regfile.sv
module regfile import core_pkg::*; (
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic [4:0]      rs1_addr_i,
    input  logic [4:0]      rs2_addr_i,
    output logic [xlen-1:0] rs1_data_o,
    output logic [xlen-1:0] rs2_data_o,
    input  logic            wr_en_i,
    input  logic [4:0]      wr_addr_i,
    input  logic [xlen-1:0] wr_data_i
);

    // x0 has no storage
    logic [xlen-1:0] regs_q [31:1];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en_i && wr_addr_i != 5'd0) begin
            regs_q[wr_addr_i] <= wr_data_i;
        end
    end

    // write-through so decode sees the result retiring this cycle
    function automatic logic [xlen-1:0] read_port(input logic [4:0] addr);
        logic [xlen-1:0] data;
        if (addr == 5'd0) begin
            data = '0;
        end else if (wr_en_i && wr_addr_i == addr) begin
            data = wr_data_i;
        end else begin
            data = regs_q[addr];
        end
        return data;
    endfunction

    always_comb begin
        rs1_data_o = read_port(rs1_addr_i);
        rs2_data_o = read_port(rs2_addr_i);
    end

endmodule

// File: hw/alu.sv
module alu import core_pkg::*; (
    input  alu_op_e         op_i,
    input  logic [xlen-1:0] a_i,
    input  logic [xlen-1:0] b_i,
    output logic [xlen-1:0] result_o
);

    logic [4:0] shamt;

    assign shamt = b_i[4:0];

    always_comb begin
        case (op_i)
            alu_add:    result_o = a_i + b_i;
            alu_sub:    result_o = a_i - b_i;
            alu_and:    result_o = a_i & b_i;
            alu_or:     result_o = a_i | b_i;
            alu_xor:    result_o = a_i ^ b_i;
            alu_slt:    result_o = xlen'($signed(a_i) < $signed(b_i));
            alu_sltu:   result_o = xlen'(a_i < b_i);
            alu_sll:    result_o = a_i << shamt;
            alu_srl:    result_o = a_i >> shamt;
            // arithmetic shift keeps the sign
            alu_sra:    result_o = $unsigned($signed(a_i) >>> shamt);
            // lui
            alu_pass_b: result_o = b_i;
            default:    result_o = '0;
        endcase
    end

endmodule

// File: hw/branch_unit.sv
module branch_unit import core_pkg::*; (
    input  dec_pkt_t        dec_i,
    output logic            taken_o,
    output logic [xlen-1:0] target_o
);

    logic equal;
    logic cond_met;

    // beq and bne share one comparator
    assign equal    = dec_i.op_a == dec_i.rs2_val;
    assign cond_met = dec_i.branch_ne ? !equal : equal;

    // jal always jumps
    assign taken_o  = dec_i.is_jal || (dec_i.is_branch && cond_met);
    assign target_o = dec_i.pc + dec_i.imm;

endmodule

// File: hw/retire_unit.sv
module retire_unit import core_pkg::*; (
    input  logic            clk,
    input  logic            rst_n_i,
    input  dec_pkt_t        dec_i,
    input  logic [xlen-1:0] alu_res_i,
    input  logic            taken_i,
    input  logic [xlen-1:0] target_i,
    output logic            rf_wr_en_o,
    output logic [4:0]      rf_wr_addr_o,
    output logic [xlen-1:0] rf_wr_data_o,
    output logic            redirect_valid_o,
    output logic [xlen-1:0] redirect_pc_o,
    output retire_t         retire_o
);

    logic [xlen-1:0] wb_data;
    retire_t         retire_q;

    // link value for jal
    assign wb_data = dec_i.is_jal ? dec_i.pc + xlen'(4) : alu_res_i;

    // ====================
    // writeback
    // ====================
    assign rf_wr_en_o   = dec_i.valid && dec_i.we && !dec_i.illegal && dec_i.rd != 5'd0;
    assign rf_wr_addr_o = dec_i.rd;
    assign rf_wr_data_o = wb_data;

    assign redirect_valid_o = dec_i.valid && taken_i;
    assign redirect_pc_o    = target_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            retire_q <= '0;
        end else begin
            retire_q.valid   <= dec_i.valid;
            retire_q.illegal <= dec_i.illegal;
            retire_q.pc      <= dec_i.pc;
            retire_q.rd      <= dec_i.rd;
            retire_q.we      <= rf_wr_en_o;
            retire_q.data    <= wb_data;
        end
    end

    assign retire_o = retire_q;

    // redirect comes from a real instruction, and the slot behind it is flushed
    assert property (@(posedge clk) disable iff (!rst_n_i)
        redirect_valid_o |-> dec_i.valid ##1 !dec_i.valid);

endmodule

// File: hw/core_top.sv
module core_top import core_pkg::*; (
    input  logic            clk,
    input  logic            rst_n_i,
    output logic            wb_cyc_o,
    output logic            wb_stb_o,
    output logic            wb_we_o,
    output logic [xlen-1:0] wb_adr_o,
    input  logic [31:0]     wb_dat_i,
    input  logic            wb_ack_i,
    output retire_t         retire_o
);

    fetch_pkt_t      fetch_pkt;
    dec_pkt_t        dec_pkt;
    exec_res_t       exec_res;
    logic [4:0]      rs1_addr;
    logic [4:0]      rs2_addr;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic            rf_wr_en;
    logic [4:0]      rf_wr_addr;
    logic [xlen-1:0] rf_wr_data;
    logic            redirect_valid;
    logic [xlen-1:0] redirect_pc;

    // ====================
    // fetch and decode
    // ====================
    fetch_unit fetch_unit_i (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .redirect_valid_i (redirect_valid),
        .redirect_pc_i    (redirect_pc),
        .wb_cyc_o         (wb_cyc_o),
        .wb_stb_o         (wb_stb_o),
        .wb_we_o          (wb_we_o),
        .wb_adr_o         (wb_adr_o),
        .wb_dat_i         (wb_dat_i),
        .wb_ack_i         (wb_ack_i),
        .fetch_o          (fetch_pkt)
    );

    decoder decoder_i (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .fetch_i    (fetch_pkt),
        .flush_i    (redirect_valid),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .dec_o      (dec_pkt)
    );

    regfile regfile_i (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wr_en_i    (rf_wr_en),
        .wr_addr_i  (rf_wr_addr),
        .wr_data_i  (rf_wr_data)
    );

    // ====================
    // execute and retire
    // ====================
    alu alu_i (
        .op_i     (dec_pkt.alu_op),
        .a_i      (dec_pkt.op_a),
        .b_i      (dec_pkt.op_b),
        .result_o (exec_res.alu_res)
    );

    branch_unit branch_unit_i (
        .dec_i    (dec_pkt),
        .taken_o  (exec_res.taken),
        .target_o (exec_res.target)
    );

    retire_unit retire_unit_i (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .dec_i            (dec_pkt),
        .alu_res_i        (exec_res.alu_res),
        .taken_i          (exec_res.taken),
        .target_i         (exec_res.target),
        .rf_wr_en_o       (rf_wr_en),
        .rf_wr_addr_o     (rf_wr_addr),
        .rf_wr_data_o     (rf_wr_data),
        .redirect_valid_o (redirect_valid),
        .redirect_pc_o    (redirect_pc),
        .retire_o         (retire_o)
    );

endmodule

// File: verification/core_tb.sv
module core_tb import core_pkg::*; ();

    localparam int prog_len = 34;
    localparam int retire_goal = 40;
    // worst case fetch plus pipeline depth, doubled, rounded up to 600
    localparam int timeout_cycles = ((retire_goal * (4 + 3) * 2 + 99) / 100) * 100;

    logic        clk;
    logic        rst_n_i;
    logic        wb_cyc_o;
    logic        wb_stb_o;
    logic        wb_we_o;
    logic [31:0] wb_adr_o;
    logic [31:0] wb_dat_i;
    logic        wb_ack_i;
    retire_t     retire_o;

    logic [31:0] prog [0:prog_len-1];
    logic [31:0] model_regs [0:31];
    logic [31:0] model_pc;
    logic [31:0] lcg_state;
    logic [31:0] rnd;
    logic [1:0]  wait_left;
    logic        ack_seen;
    int          value_errors;
    int          protocol_errors;
    int          retire_count;
    int          cycle_count;

    core_top core_top_i (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .wb_cyc_o (wb_cyc_o),
        .wb_stb_o (wb_stb_o),
        .wb_we_o  (wb_we_o),
        .wb_adr_o (wb_adr_o),
        .wb_dat_i (wb_dat_i),
        .wb_ack_i (wb_ack_i),
        .retire_o (retire_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ====================
    // instruction encoders
    // ====================
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // past the program end every word is a jump to itself
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        if (addr[31:2] < prog_len) begin
            return prog[addr[31:2]];
        end
        return 32'h0000006f;
    endfunction

    // ====================
    // reference model
    // ====================
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic model_step(output logic ill, output logic we, output logic [4:0] rd,
                              output logic [31:0] data);
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] next_pc;
        logic [2:0]  f3;
        logic [6:0]  f7;
        ins = mem_word(model_pc);
        f3 = ins[14:12];
        f7 = ins[31:25];
        rd = ins[11:7];
        a = model_regs[ins[19:15]];
        b = model_regs[ins[24:20]];
        next_pc = model_pc + 32'd4;
        ill = 1'b0;
        we = 1'b0;
        data = '0;
        case (ins[6:0])
            7'b0110011: begin
                ill = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
                we = 1'b1;
                data = alu_ref(f3, f7[5], a, b);
            end
            7'b0010011: begin
                b = {{20{ins[31]}}, ins[31:20]};
                ill = (f3 == 3'd1 && f7 != 7'h00) ||
                      (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20);
                we = 1'b1;
                data = alu_ref(f3, f3 == 3'd5 && f7[5], a, b);
            end
            7'b0110111: begin
                we = 1'b1;
                data = {ins[31:12], 12'b0};
            end
            7'b1100011: begin
                ill = f3[2:1] != 2'b00;
                if (!ill && ((a == b) != f3[0])) begin
                    next_pc = model_pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25],
                                          ins[11:8], 1'b0};
                end
            end
            7'b1101111: begin
                we = 1'b1;
                data = model_pc + 32'd4;
                next_pc = model_pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20],
                                      ins[30:21], 1'b0};
            end
            default: ill = 1'b1;
        endcase
        we = we && !ill && rd != 5'd0;
        if (we) begin
            model_regs[rd] = data;
        end
        model_pc = next_pc;
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        value_errors++;
        $display("Error %s: got 0x%h, expected 0x%h", name, got, exp);
    endtask

    task automatic report_protocol(input string what);
        protocol_errors++;
        $display("%s at time %0t", what, $time);
    endtask

    task automatic print_summary();
        $display("%0d value errors, %0d protocol errors, %0d instructions retired",
                 value_errors, protocol_errors, retire_count);
    endtask

    // ====================
    // wishbone memory with random wait states
    // ====================
    always @(posedge clk) begin
        ack_seen = wb_ack_i;
        #1;
        if (!rst_n_i) begin
            wb_ack_i = 1'b0;
            rnd = lcg_next();
            wait_left = rnd[17:16];
        end else begin
            // new wait count per request, zero wait keeps ack high back to back
            if (ack_seen) begin
                rnd = lcg_next();
                wait_left = rnd[17:16];
            end
            if (wb_cyc_o && wb_stb_o && wait_left == 2'd0) begin
                wb_ack_i = 1'b1;
                wb_dat_i = mem_word(wb_adr_o);
            end else begin
                wb_ack_i = 1'b0;
                if (wb_cyc_o && wb_stb_o) begin
                    wait_left = wait_left - 2'd1;
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n_i)
        wb_stb_o && !wb_ack_i |=> wb_stb_o && $stable(wb_adr_o))
        else report_protocol("strobe dropped or address moved while waiting for ack");

    assert property (@(posedge clk) disable iff (!rst_n_i) wb_cyc_o |-> !wb_we_o)
        else report_protocol("write enable raised on the instruction port");

    // retire records are stable around the falling edge
    always @(negedge clk) begin
        logic        exp_ill;
        logic        exp_we;
        logic [4:0]  exp_rd;
        logic [31:0] exp_data;
        logic [31:0] exp_pc;
        if (rst_n_i && retire_o.valid) begin
            exp_pc = model_pc;
            model_step(exp_ill, exp_we, exp_rd, exp_data);
            assert (retire_o.pc == exp_pc)
                else report_mismatch("retire_o.pc", retire_o.pc, exp_pc);
            assert (retire_o.illegal == exp_ill)
                else report_mismatch("retire_o.illegal", 32'(retire_o.illegal), 32'(exp_ill));
            assert (retire_o.we == exp_we)
                else report_mismatch("retire_o.we", 32'(retire_o.we), 32'(exp_we));
            if (exp_we) begin
                assert (retire_o.rd == exp_rd)
                    else report_mismatch("retire_o.rd", 32'(retire_o.rd), 32'(exp_rd));
                assert (retire_o.data == exp_data)
                    else report_mismatch("retire_o.data", retire_o.data, exp_data);
            end
            retire_count++;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout after %0d cycles with only %0d of %0d instructions retired",
                     cycle_count, retire_count, retire_goal);
            print_summary();
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        rst_n_i = 1'b0;
        wb_ack_i = 1'b0;
        wb_dat_i = '0;
        lcg_state = 32'h02c79ba5;
        wait_left = 2'd0;
        value_errors = 0;
        protocol_errors = 0;
        retire_count = 0;
        cycle_count = 0;
        model_pc = 32'h0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        prog[0]  = i_type(3'd0, 5'd1, 5'd0, 12'd5);
        prog[1]  = i_type(3'd0, 5'd2, 5'd0, -12'd3);
        prog[2]  = r_type(7'h00, 3'd0, 5'd3, 5'd1, 5'd2);
        prog[3]  = r_type(7'h20, 3'd0, 5'd4, 5'd1, 5'd2);
        prog[4]  = r_type(7'h00, 3'd7, 5'd5, 5'd3, 5'd4);
        prog[5]  = r_type(7'h00, 3'd6, 5'd6, 5'd1, 5'd2);
        prog[6]  = r_type(7'h00, 3'd4, 5'd7, 5'd6, 5'd1);
        prog[7]  = r_type(7'h00, 3'd2, 5'd8, 5'd2, 5'd1);
        prog[8]  = r_type(7'h00, 3'd3, 5'd9, 5'd2, 5'd1);
        prog[9]  = r_type(7'h00, 3'd1, 5'd10, 5'd1, 5'd3);
        prog[10] = r_type(7'h00, 3'd5, 5'd11, 5'd2, 5'd1);
        prog[11] = r_type(7'h20, 3'd5, 5'd12, 5'd2, 5'd1);
        prog[12] = {20'h12345, 5'd13, 7'b0110111};
        prog[13] = i_type(3'd4, 5'd14, 5'd13, 12'h7ff);
        prog[14] = i_type(3'd2, 5'd15, 5'd2, 12'd0);
        prog[15] = i_type(3'd3, 5'd16, 5'd1, 12'd6);
        prog[16] = i_type(3'd1, 5'd17, 5'd1, 12'd3);
        prog[17] = i_type(3'd5, 5'd18, 5'd2, 12'd4);
        prog[18] = i_type(3'd5, 5'd19, 5'd2, 12'h401);
        prog[19] = i_type(3'd6, 5'd20, 5'd1, 12'h0f0);
        prog[20] = i_type(3'd7, 5'd21, 5'd13, -12'd1);
        // write to x0, then read it back
        prog[21] = i_type(3'd0, 5'd0, 5'd1, 12'd7);
        prog[22] = r_type(7'h00, 3'd0, 5'd22, 5'd0, 5'd1);
        // lw x1, 0(x0) is outside the supported set
        prog[23] = 32'h00002083;
        prog[24] = b_type(3'd0, 5'd1, 5'd1, 13'd8);
        prog[25] = i_type(3'd0, 5'd23, 5'd0, 12'd1);
        prog[26] = b_type(3'd1, 5'd1, 5'd1, 13'd8);
        prog[27] = b_type(3'd1, 5'd1, 5'd2, 13'd8);
        prog[28] = i_type(3'd0, 5'd24, 5'd0, 12'd1);
        prog[29] = b_type(3'd0, 5'd1, 5'd2, 13'd8);
        prog[30] = j_type(5'd25, 21'd8);
        prog[31] = i_type(3'd0, 5'd26, 5'd0, 12'd1);
        prog[32] = i_type(3'd0, 5'd27, 5'd25, 12'd4);
        // back to address zero
        prog[33] = j_type(5'd0, -21'd132);

        repeat (8) @(posedge clk);
        #1;
        rst_n_i = 1'b1;
        assert (!wb_cyc_o && !retire_o.valid)
            else report_protocol("bus cycle or retire valid active right after reset");
        @(posedge clk);
        #1;
        assert (wb_cyc_o && wb_stb_o)
            else report_protocol("no fetch request on the first edge after reset");
        assert (wb_adr_o == 32'h0)
            else report_mismatch("wb_adr_o", wb_adr_o, 32'h0);

        wait (retire_count >= retire_goal);
        print_summary();
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: flist.f
hw/core_pkg.sv
hw/fetch_unit.sv
hw/decoder.sv
hw/regfile.sv
hw/alu.sv
hw/branch_unit.sv
hw/retire_unit.sv
hw/core_top.sv
verification/core_tb.sv

// File: Bender.yml
package:
  name: core

sources:
  - hw/core_pkg.sv
  - hw/fetch_unit.sv
  - hw/decoder.sv
  - hw/regfile.sv
  - hw/alu.sv
  - hw/branch_unit.sv
  - hw/retire_unit.sv
  - hw/core_top.sv
  - target: test
    files:
      - verification/core_tb.sv
